//--- verilog.f
+incdir+verilog
verilog/pci_pkg.sv
verilog/pci_master_ctrl.sv
verilog/pci_master_datapath.sv
verilog/pci_target.sv
verilog/pci_subsys_top.sv
verification/pci_clk_gen.sv
verification/pci_subsys_tb.sv

//--- Makefile
# Verilator flow for the PCI subsystem.
# Any variable can be overridden, e.g. make sim TOP=pci_subsys_tb OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= pci_subsys_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ns
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# The run passes only if the pass message shows up in the simulator output.
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/pci_subsys_tb.sv
`timescale 1ns/1ns
`include "pci_params.svh"

module pci_subsys_tb;

	localparam logic [31:0] BAR  = 32'h8000_1200;  // Programmed into BAR0 by the first row.
	localparam logic [31:0] CFG  = 32'h0001_0000;  // AD16 drives IDSEL.
	localparam logic [31:0] ONES = 32'hffff_ffff;

	logic              clk;
	logic              arst_n;
	logic              cmd_valid;
	pci_pkg::pci_cmd_t cmd;
	logic              gnt_n;
	logic              req_n;
	logic              busy;
	logic              rsp_valid;
	pci_pkg::pci_rsp_t rsp;

	string             names [$];
	pci_pkg::pci_cmd_t cmds [$];
	pci_pkg::pci_rsp_t exps [$];
	logic [31:0]       lcg_q;
	int                cycles = 0;

	pci_clk_gen pci_clk_gen_i (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	pci_subsys_top pci_subsys_top_i (
		.clk         (clk),
		.arst_n_i    (arst_n),
		.cmd_valid_i (cmd_valid),
		.cmd_i       (cmd),
		.gnt_n_i     (gnt_n),
		.req_n_o     (req_n),
		.busy_o      (busy),
		.rsp_valid_o (rsp_valid),
		.rsp_o       (rsp)
	);

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------

	function automatic logic [31:0] lcg_next();
		lcg_q = lcg_q * 32'd1103515245 + 32'd12345;
		return lcg_q;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_data(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (act_v !== exp_v) begin
			stop_on_error($sformatf("Fail %s: expected data %h, actual %h", name, exp_v, act_v));
		end
	endtask

	task automatic check_status(input string name, input pci_pkg::pci_status_e exp_v,
			input pci_pkg::pci_status_e act_v);
		if (act_v !== exp_v) begin
			stop_on_error($sformatf("Fail %s: expected status %s, actual %s", name,
				exp_v.name(), act_v.name()));
		end
	endtask

	task automatic add_row(input string name, input pci_pkg::pci_cmd_e kind,
			input logic [31:0] addr, input logic [31:0] data, input logic [3:0] be,
			input pci_pkg::pci_status_e sts, input logic [31:0] rd);
		pci_pkg::pci_cmd_t c;
		pci_pkg::pci_rsp_t r;
		c = '{cmd: kind, addr: addr, data: data, be: be};
		r = '{data: rd, status: sts};
		names.push_back(name);
		cmds.push_back(c);
		exps.push_back(r);
	endtask

	// Read data is checked for reads and for master aborts only.
	task automatic build_table();
		add_row("cfg_wr_bar0", pci_pkg::CMD_CONF_WRITE, CFG + 32'h10, 32'h8000_12ab, 4'hf,
			pci_pkg::STS_OK, 32'h0);
		add_row("cfg_rd_bar0", pci_pkg::CMD_CONF_READ, CFG + 32'h10, 32'h0, 4'hf,
			pci_pkg::STS_OK, 32'h8000_1200);                 // Low 8 bits read as zero.
		add_row("mem_wr_0", pci_pkg::CMD_MEM_WRITE, BAR, 32'h1122_3344, 4'hf,
			pci_pkg::STS_OK, 32'h0);
		add_row("mem_wr_1", pci_pkg::CMD_MEM_WRITE, BAR + 32'h4, 32'ha5a5_a5a5, 4'hf,
			pci_pkg::STS_OK, 32'h0);
		add_row("mem_be_1", pci_pkg::CMD_MEM_WRITE, BAR + 32'h4, 32'hdead_beef, 4'b0101,
			pci_pkg::STS_OK, 32'h0);
		add_row("mem_be_0", pci_pkg::CMD_MEM_WRITE, BAR, 32'h0000_ff00, 4'b0010,
			pci_pkg::STS_OK, 32'h0);
		add_row("mem_rd_1", pci_pkg::CMD_MEM_READ, BAR + 32'h4, 32'h0, 4'hf,
			pci_pkg::STS_OK, 32'ha5ad_a5ef);                 // Bytes 0 and 2 merged.
		add_row("mem_rd_0", pci_pkg::CMD_MEM_READ, BAR, 32'h0, 4'hf,
			pci_pkg::STS_OK, 32'h1122_ff44);
		add_row("mem_miss_rd", pci_pkg::CMD_MEM_READ, BAR + 32'h100, 32'h0, 4'hf,
			pci_pkg::STS_MASTER_ABORT, ONES);
		add_row("mem_miss_wr", pci_pkg::CMD_MEM_WRITE, 32'h4000_0000, 32'h1234_5678, 4'hf,
			pci_pkg::STS_MASTER_ABORT, ONES);
		add_row("cfg_no_idsel", pci_pkg::CMD_CONF_READ, 32'h0000_0010, 32'h0, 4'hf,
			pci_pkg::STS_MASTER_ABORT, ONES);
		add_row("io_wr_0", pci_pkg::CMD_IO_WRITE, `PCI_IO_BASE, 32'hcafe_0001, 4'hf,
			pci_pkg::STS_OK, 32'h0);
		add_row("io_wr_3", pci_pkg::CMD_IO_WRITE, `PCI_IO_BASE + 32'hc, 32'h0bad_f00d, 4'hf,
			pci_pkg::STS_OK, 32'h0);
		add_row("io_rd_0", pci_pkg::CMD_IO_READ, `PCI_IO_BASE, 32'h0, 4'hf,
			pci_pkg::STS_OK, 32'hcafe_0001);
		add_row("io_rd_3", pci_pkg::CMD_IO_READ, `PCI_IO_BASE + 32'hc, 32'h0, 4'hf,
			pci_pkg::STS_OK, 32'h0bad_f00d);
		add_row("io_miss", pci_pkg::CMD_IO_READ, `PCI_IO_BASE + 32'h10, 32'h0, 4'hf,
			pci_pkg::STS_MASTER_ABORT, ONES);
		add_row("mem_keep_0", pci_pkg::CMD_MEM_READ, BAR, 32'h0, 4'hf,
			pci_pkg::STS_OK, 32'h1122_ff44);
		add_row("mem_keep_1", pci_pkg::CMD_MEM_READ, BAR + 32'h4, 32'h0, 4'hf,
			pci_pkg::STS_OK, 32'ha5ad_a5ef);
		add_row("cfg_wr_id", pci_pkg::CMD_CONF_WRITE, CFG, 32'h0, 4'hf,
			pci_pkg::STS_TARGET_ABORT, 32'h0);
		add_row("cfg_rd_id", pci_pkg::CMD_CONF_READ, CFG, 32'h0, 4'hf,
			pci_pkg::STS_OK, `PCI_DEVICE_ID);
	endtask

	// --------------------------------------------------
	// One transaction with a random grant delay
	// --------------------------------------------------

	task automatic run_row(input int idx);
		int delay;
		delay = int'(lcg_next() >> 16) % 8;
		@(negedge clk);
		if (busy !== 1'b0) begin
			stop_on_error($sformatf("%s: DUT still busy before the strobe", names[idx]));
		end
		cmd_valid = 1'b1;
		cmd       = cmds[idx];
		gnt_n     = 1'b1;
		@(negedge clk);
		cmd_valid = 1'b0;
		if (busy !== 1'b1) begin
			stop_on_error($sformatf("%s: command strobe was not accepted", names[idx]));
		end
		repeat (delay) begin
			if (req_n !== 1'b0 || rsp_valid !== 1'b0) begin
				stop_on_error($sformatf("%s: bus request dropped or result without grant",
					names[idx]));
			end
			@(negedge clk);
		end
		gnt_n = 1'b0;
		while (rsp_valid !== 1'b1) begin
			@(negedge clk);
		end
		gnt_n = 1'b1;
		if (req_n !== 1'b1) begin
			stop_on_error($sformatf("%s: request still low in turnaround", names[idx]));
		end
		check_status(names[idx], exps[idx].status, rsp.status);
		if (exps[idx].status == pci_pkg::STS_MASTER_ABORT ||
				cmds[idx].cmd inside {pci_pkg::CMD_IO_READ, pci_pkg::CMD_MEM_READ,
				pci_pkg::CMD_CONF_READ}) begin
			check_data(names[idx], exps[idx].data, rsp.data);
		end
	endtask

	// --------------------------------------------------
	// Main sequence and timeout
	// --------------------------------------------------

	initial begin
		cmd_valid = 1'b0;
		cmd       = '0;
		gnt_n     = 1'b1;
		lcg_q     = 32'd39286;
		build_table();
		@(posedge arst_n);
		@(negedge clk);
		if (req_n !== 1'b1 || busy !== 1'b0 || rsp_valid !== 1'b0) begin
			stop_on_error("Outputs are not idle after reset");
		end
		for (int i = 0; i < names.size(); i++) begin
			run_row(i);
		end
		$display("Simulation passed");
		$finish;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > names.size() * 30) begin
			stop_on_error($sformatf("Timeout: the tests did not finish in %0d cycles", cycles));
		end
	end

endmodule

//--- verification/pci_clk_gen.sv
`timescale 1ns/1ns

module pci_clk_gen (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;                 // 10 ns period.
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (2) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1;                           // Released away from the active edge.
	end

endmodule

//--- verilog/pci_subsys_top.sv
`timescale 1ns/1ns

module pci_subsys_top (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              cmd_valid_i,
	input  pci_pkg::pci_cmd_t cmd_i,
	input  logic              gnt_n_i,
	output logic              req_n_o,
	output logic              busy_o,
	output logic              rsp_valid_o,
	output pci_pkg::pci_rsp_t rsp_o
);

	pci_pkg::pci_init_bus_t init_bus;
	pci_pkg::pci_tgt_bus_t  tgt_bus;
	pci_pkg::pci_status_e   status;
	logic                   load;
	logic                   capture;
	logic                   master_abort;
	logic [1:0]             phase;
	logic [31:0]            rd_data;

	assign master_abort = (status == pci_pkg::STS_MASTER_ABORT);

	pci_master_ctrl pci_master_ctrl_i (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.cmd_valid_i (cmd_valid_i),
		.cmd_kind_i  (cmd_i.cmd),
		.gnt_n_i     (gnt_n_i),
		.tgt_i       (tgt_bus),
		.req_n_o     (req_n_o),
		.busy_o      (busy_o),
		.load_o      (load),
		.phase_o     (phase),
		.capture_o   (capture),
		.rsp_valid_o (rsp_valid_o),
		.status_o    (status)
	);

	pci_master_datapath pci_master_datapath_i (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.cmd_i     (cmd_i),
		.load_i    (load),
		.phase_i   (phase),
		.capture_i (capture),
		.abort_i   (master_abort),
		.tgt_i     (tgt_bus),
		.bus_o     (init_bus),
		.rd_data_o (rd_data)
	);

	pci_target pci_target_i (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.bus_i    (init_bus),
		.idsel_i  (init_bus.ad[16]),       // IDSEL taken from AD16.
		.tgt_o    (tgt_bus)
	);

	assign rsp_o = '{data: rd_data, status: status};

endmodule

//--- verilog/pci_target.sv
`timescale 1ns/1ns
`include "pci_params.svh"

module pci_target (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  pci_pkg::pci_init_bus_t bus_i,
	input  logic                   idsel_i,
	output pci_pkg::pci_tgt_bus_t  tgt_o
);

	localparam int          MEM_IW   = $clog2(`PCI_MEM_WORDS);
	localparam int          IO_IW    = $clog2(`PCI_IO_WORDS);
	localparam int          WAIT_W   = $clog2(`PCI_WAIT_STATES + 1);
	localparam logic [31:0] BAR_MASK = ~((32'd1 << `PCI_BAR_MASK_BITS) - 32'd1);
	localparam logic [31:0] IO_SPAN  = 32'(4 * `PCI_IO_WORDS);

	logic [31:0]       mem_q [`PCI_MEM_WORDS];
	logic [31:0]       io_q [`PCI_IO_WORDS];
	logic [31:0]       bar0_q;
	logic [31:0]       addr_q;
	pci_pkg::pci_cmd_e cmd_q;
	logic              frame_n_q;
	logic              sel_q;
	logic [WAIT_W-1:0] wait_q;
	logic              devsel_n_q;
	logic              trdy_n_q;
	logic              stop_n_q;
	logic              perr_n_q;
	logic              par_q;
	logic [31:0]       ad_q;
	logic              chk_q;
	logic              dat_par_q;

	logic              addr_phase;
	logic              hit;
	logic              is_conf;
	logic              is_mem;
	logic              is_io;
	logic              is_write;
	logic              abort;
	logic              done;
	logic              wr_en;
	logic [5:0]        cfg_idx;
	logic [MEM_IW-1:0] mem_idx;
	logic [IO_IW-1:0]  io_idx;
	logic [31:0]       rd_data;
	logic [31:0]       wr_data;

	function automatic logic [31:0] merge_be(input logic [31:0] old_v,
			input logic [31:0] new_v, input logic [3:0] cbe_n);
		logic [31:0] res;
		res = old_v;
		for (int b = 0; b < 4; b++) begin
			if (!cbe_n[b]) begin
				res[8*b +: 8] = new_v[8*b +: 8];
			end
		end
		return res;
	endfunction

	// --------------------------------------------------
	// Address decode
	// --------------------------------------------------

	assign addr_phase = !bus_i.frame_n && frame_n_q;

	always_comb begin
		case (bus_i.cbe_n)
			pci_pkg::CMD_CONF_READ, pci_pkg::CMD_CONF_WRITE: hit = idsel_i;
			pci_pkg::CMD_MEM_READ, pci_pkg::CMD_MEM_WRITE: hit = (bus_i.ad & BAR_MASK) == bar0_q;
			pci_pkg::CMD_IO_READ, pci_pkg::CMD_IO_WRITE: hit = (bus_i.ad - `PCI_IO_BASE) < IO_SPAN;
			default: hit = 1'b0;
		endcase
	end

	assign is_conf  = cmd_q inside {pci_pkg::CMD_CONF_READ, pci_pkg::CMD_CONF_WRITE};
	assign is_mem   = cmd_q inside {pci_pkg::CMD_MEM_READ, pci_pkg::CMD_MEM_WRITE};
	assign is_io    = cmd_q inside {pci_pkg::CMD_IO_READ, pci_pkg::CMD_IO_WRITE};
	assign is_write = pci_pkg::cmd_is_write(cmd_q);
	assign cfg_idx  = addr_q[7:2];
	assign mem_idx  = addr_q[MEM_IW+1:2];
	assign io_idx   = addr_q[IO_IW+1:2];
	assign abort    = is_conf && is_write && (cfg_idx == 6'd0); // Device ID is read only.
	assign done     = sel_q && !bus_i.irdy_n && (!trdy_n_q || !stop_n_q);
	assign wr_en    = done && !trdy_n_q && is_write;

	always_comb begin
		rd_data = '0;
		if (is_conf) begin
			if (cfg_idx == 6'd0) begin
				rd_data = `PCI_DEVICE_ID;
			end else if (cfg_idx == 6'd4) begin
				rd_data = bar0_q;
			end
		end else if (is_mem) begin
			rd_data = mem_q[mem_idx];
		end else if (is_io) begin
			rd_data = io_q[io_idx];
		end
	end

	assign wr_data = merge_be(rd_data, bus_i.ad, bus_i.cbe_n);

	// --------------------------------------------------
	// Response timing and parity check
	// --------------------------------------------------

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			frame_n_q  <= 1'b1;
			sel_q      <= 1'b0;
			wait_q     <= '0;
			devsel_n_q <= 1'b1;
			trdy_n_q   <= 1'b1;
			stop_n_q   <= 1'b1;
			perr_n_q   <= 1'b1;
			chk_q      <= 1'b0;
			par_q      <= 1'b0;
			ad_q       <= '0;
			bar0_q     <= '0;
		end else begin
			frame_n_q <= bus_i.frame_n;
			par_q     <= ^{ad_q, bus_i.cbe_n};
			chk_q     <= sel_q && is_write && !bus_i.irdy_n;
			perr_n_q  <= !(chk_q && (dat_par_q != bus_i.par)); // PAR lags data by one.
			if (done) begin
				sel_q      <= 1'b0;
				devsel_n_q <= 1'b1;
				trdy_n_q   <= 1'b1;
				stop_n_q   <= 1'b1;
			end else if (addr_phase && hit) begin
				sel_q      <= 1'b1;
				devsel_n_q <= 1'b0;
				wait_q     <= WAIT_W'(`PCI_WAIT_STATES - 1);
			end else if (sel_q && trdy_n_q && stop_n_q) begin
				if (wait_q == '0) begin
					if (abort) begin
						stop_n_q <= 1'b0;
					end else begin
						trdy_n_q <= 1'b0;
						ad_q     <= rd_data;
					end
				end else begin
					wait_q <= wait_q - 1'b1;
				end
			end
			if (wr_en && is_conf && cfg_idx == 6'd4) begin
				bar0_q <= wr_data & BAR_MASK;
			end
		end
	end

	always_ff @(posedge clk) begin
		dat_par_q <= ^{bus_i.ad, bus_i.cbe_n};
		if (addr_phase) begin
			addr_q <= bus_i.ad;
			cmd_q  <= pci_pkg::pci_cmd_e'(bus_i.cbe_n);
		end
		if (wr_en && is_mem) begin
			mem_q[mem_idx] <= wr_data;
		end
		if (wr_en && is_io) begin
			io_q[io_idx] <= wr_data;
		end
	end

	assign tgt_o = '{ad: ad_q, par: par_q, devsel_n: devsel_n_q, trdy_n: trdy_n_q,
		stop_n: stop_n_q, perr_n: perr_n_q};

endmodule

//--- verilog/pci_master_datapath.sv
`timescale 1ns/1ns

module pci_master_datapath (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  pci_pkg::pci_cmd_t      cmd_i,
	input  logic                   load_i,
	input  logic [1:0]             phase_i,
	input  logic                   capture_i,
	input  logic                   abort_i,
	input  pci_pkg::pci_tgt_bus_t  tgt_i,
	output pci_pkg::pci_init_bus_t bus_o,
	output logic [31:0]            rd_data_o
);

	pci_pkg::pci_cmd_t cmd_q;
	logic              is_read;
	logic              par_q;
	logic [31:0]       rd_data_q;

	assign is_read = !pci_pkg::cmd_is_write(cmd_q.cmd);

	always_ff @(posedge clk) begin
		if (load_i) begin
			cmd_q <= cmd_i;
		end
	end

	// --------------------------------------------------
	// Bus drive
	// --------------------------------------------------

	always_comb begin
		bus_o.ad      = '0;
		bus_o.cbe_n   = '1;
		bus_o.par     = par_q;
		bus_o.frame_n = 1'b1;
		bus_o.irdy_n  = 1'b1;
		if (phase_i[0]) begin
			bus_o.ad      = cmd_q.addr;
			bus_o.cbe_n   = cmd_q.cmd;
			bus_o.frame_n = 1'b0;
		end else if (phase_i[1]) begin
			bus_o.irdy_n = 1'b0;
			if (is_read) begin
				bus_o.cbe_n = 4'h0;                // All lanes for reads.
			end else begin
				bus_o.ad    = cmd_q.data;
				bus_o.cbe_n = ~cmd_q.be;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			par_q <= 1'b0;
		end else begin
			par_q <= ^{bus_o.ad, bus_o.cbe_n};     // Even parity, one cycle late.
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			rd_data_q <= '0;
		end else if (abort_i) begin
			rd_data_q <= '1;
		end else if (capture_i) begin
			rd_data_q <= tgt_i.ad;
		end
	end

	assign rd_data_o = rd_data_q;

endmodule

//--- verilog/pci_master_ctrl.sv
`timescale 1ns/1ns
`include "pci_params.svh"

module pci_master_ctrl (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  cmd_valid_i,
	input  pci_pkg::pci_cmd_e     cmd_kind_i,
	input  logic                  gnt_n_i,
	input  pci_pkg::pci_tgt_bus_t tgt_i,
	output logic                  req_n_o,
	output logic                  busy_o,
	output logic                  load_o,
	output logic [1:0]            phase_o,
	output logic                  capture_o,
	output logic                  rsp_valid_o,
	output pci_pkg::pci_status_e  status_o
);

	localparam int CNT_W = $clog2(`PCI_ABORT_CYCLES + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REQ,
		ST_ADDR,
		ST_DATA,
		ST_TURN
	} state_e;

	state_e               state_q;
	state_e               state_d;
	logic                 is_read_q;
	logic [CNT_W-1:0]     cnt_q;
	logic                 perr_seen_q;
	pci_pkg::pci_status_e sts_q;
	logic                 accept;
	logic                 timeout;
	logic                 done;

	assign accept = cmd_valid_i && (state_q == ST_IDLE);

	// No DEVSEL within the abort window ends the cycle.
	assign timeout = (state_q == ST_DATA) && tgt_i.devsel_n &&
		(cnt_q == CNT_W'(`PCI_ABORT_CYCLES - 1));

	assign done = (state_q == ST_DATA) && (!tgt_i.trdy_n || !tgt_i.stop_n || timeout);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: if (cmd_valid_i) state_d = ST_REQ;
			ST_REQ:  if (!gnt_n_i) state_d = ST_ADDR;
			ST_ADDR: state_d = ST_DATA;
			ST_DATA: if (done) state_d = ST_TURN;
			ST_TURN: state_d = ST_IDLE;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= ST_IDLE;
			is_read_q   <= 1'b0;
			cnt_q       <= '0;
			perr_seen_q <= 1'b0;
			sts_q       <= pci_pkg::STS_OK;
		end else begin
			state_q <= state_d;
			if (accept) begin
				is_read_q   <= !pci_pkg::cmd_is_write(cmd_kind_i);
				perr_seen_q <= 1'b0;
			end
			if (state_q == ST_ADDR) begin
				cnt_q <= '0;
			end else if (state_q == ST_DATA && tgt_i.devsel_n) begin
				cnt_q <= cnt_q + 1'b1;
			end
			if (state_q == ST_DATA && !tgt_i.perr_n) begin
				perr_seen_q <= 1'b1;
			end
			if (done) begin
				if (!tgt_i.stop_n) begin
					sts_q <= pci_pkg::STS_TARGET_ABORT;
				end else if (timeout) begin
					sts_q <= pci_pkg::STS_MASTER_ABORT;
				end else begin
					sts_q <= pci_pkg::STS_OK;
				end
			end
		end
	end

	// --------------------------------------------------
	// Outputs
	// --------------------------------------------------

	assign load_o      = accept;
	assign busy_o      = (state_q != ST_IDLE);
	assign req_n_o     = !(state_q inside {ST_REQ, ST_ADDR, ST_DATA});
	assign phase_o     = {state_q == ST_DATA, state_q == ST_ADDR}; // Bit 1 data, bit 0 address.
	assign capture_o   = (state_q == ST_DATA) && is_read_q && !tgt_i.trdy_n;
	assign rsp_valid_o = (state_q == ST_TURN);

	// Master abort shows early so the datapath can load all ones.
	// PERR for a write lands in the turnaround cycle.
	always_comb begin
		status_o = pci_pkg::STS_OK;
		if (timeout) begin
			status_o = pci_pkg::STS_MASTER_ABORT;
		end else if (state_q == ST_TURN) begin
			status_o = sts_q;
			if (sts_q == pci_pkg::STS_OK && (perr_seen_q || !tgt_i.perr_n)) begin
				status_o = pci_pkg::STS_PARITY_ERR;
			end
		end
	end

endmodule

//--- verilog/pci_pkg.sv
package pci_pkg;

	// --------------------------------------------------
	// Command and result codes
	// --------------------------------------------------

	typedef enum logic [3:0] {
		CMD_IO_READ    = 4'h2,
		CMD_IO_WRITE   = 4'h3,
		CMD_MEM_READ   = 4'h6,
		CMD_MEM_WRITE  = 4'h7,
		CMD_CONF_READ  = 4'hA,
		CMD_CONF_WRITE = 4'hB
	} pci_cmd_e;

	typedef enum logic [1:0] {
		STS_OK           = 2'd0,
		STS_MASTER_ABORT = 2'd1,
		STS_TARGET_ABORT = 2'd2,
		STS_PARITY_ERR   = 2'd3
	} pci_status_e;

	// --------------------------------------------------
	// Requests, results and the two bus directions
	// --------------------------------------------------

	typedef struct packed {
		pci_cmd_e    cmd;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  be;       // Active high.
	} pci_cmd_t;

	typedef struct packed {
		logic [31:0] data;
		pci_status_e status;
	} pci_rsp_t;

	typedef struct packed {
		logic [31:0] ad;
		logic [3:0]  cbe_n;
		logic        par;
		logic        frame_n;
		logic        irdy_n;
	} pci_init_bus_t;

	typedef struct packed {
		logic [31:0] ad;
		logic        par;
		logic        devsel_n;
		logic        trdy_n;
		logic        stop_n;
		logic        perr_n;
	} pci_tgt_bus_t;

	function automatic logic cmd_is_write(input pci_cmd_e cmd);
		return cmd inside {CMD_IO_WRITE, CMD_MEM_WRITE, CMD_CONF_WRITE};
	endfunction

endpackage

//--- verilog/pci_params.svh
`ifndef PCI_PARAMS_SVH
`define PCI_PARAMS_SVH

// --------------------------------------------------
// Target address map
// --------------------------------------------------

`define PCI_MEM_WORDS 64            // Memory window depth in dwords.
`define PCI_BAR_MASK_BITS 8         // BAR0 low bits reading as zero, 256-byte window.
`define PCI_IO_BASE 32'h0000_1000   // Fixed I/O base.
`define PCI_IO_WORDS 4              // I/O register count.

// --------------------------------------------------
// Bus timing
// --------------------------------------------------

`define PCI_WAIT_STATES 1           // DEVSEL to TRDY, at least one.
`define PCI_ABORT_CYCLES 5          // Cycles without DEVSEL before master abort.

// --------------------------------------------------
// Fixed configuration values
// --------------------------------------------------

`define PCI_DEVICE_ID 32'h5a17_0c3e // Read only, configuration index 0.

`endif
